// ==== filelist.f ====
+incdir+tb
src/kb_pkg.sv
src/ps2_rx.sv
src/kb_decoder.sv
src/scan_to_ascii.sv
src/key_fifo.sv
src/kb_axil_regs.sv
src/ps2_kbd_top.sv
tb/tb_ps2_kbd.sv

// ==== src/kb_axil_regs.sv ====
module kb_axil_regs #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [3:0]         s_awaddr,
    input  logic               s_awvalid,
    output logic               s_awready,
    input  logic [31:0]        s_wdata,
    input  logic [3:0]         s_wstrb,
    input  logic               s_wvalid,
    output logic               s_wready,
    output logic [1:0]         s_bresp,
    output logic               s_bvalid,
    input  logic               s_bready,
    input  logic [3:0]         s_araddr,
    input  logic               s_arvalid,
    output logic               s_arready,
    output logic [31:0]        s_rdata,
    output logic [1:0]         s_rresp,
    output logic               s_rvalid,
    input  logic               s_rready,
    input  kb_pkg::key_event_t rdata,
    input  logic               empty,
    input  logic [7:0]         count,
    input  logic               overflow,
    input  logic               frame_err,
    input  logic [7:0]         release_cnt,
    output logic               pop,
    output logic               ovf_clr,
    output logic               cnt_clr
);

    logic        wr_hs;
    logic        rd_hs;
    logic        wr_known;
    logic        rd_known;
    logic        ctrl_clr;
    logic        ferr_q;
    logic [31:0] data_word;
    logic [31:0] status_word;
    logic [31:0] rd_word;

    assign wr_hs    = s_awready && s_awvalid && s_wvalid;
    assign rd_hs    = s_arready && s_arvalid;
    assign wr_known = (s_awaddr == kb_pkg::REG_DATA) || (s_awaddr == kb_pkg::REG_STATUS) ||
                      (s_awaddr == kb_pkg::REG_CTRL);
    assign rd_known = (s_araddr == kb_pkg::REG_DATA) || (s_araddr == kb_pkg::REG_STATUS) ||
                      (s_araddr == kb_pkg::REG_CTRL);

    // only bit 0 of CTRL does anything
    assign ctrl_clr = wr_hs && (s_awaddr == kb_pkg::REG_CTRL) && s_wstrb[0] && s_wdata[0];
    assign ovf_clr  = ctrl_clr;
    assign cnt_clr  = ctrl_clr;
    assign pop      = rd_hs && (s_araddr == kb_pkg::REG_DATA) && !empty;

    assign data_word   = empty ? 32'h0 :
                         {1'b1, 13'h0, rdata.ctrl, rdata.shift, rdata.ascii, rdata.scan};
    assign status_word = {8'h0, release_cnt, 6'h0, ferr_q, overflow, count};

    always_comb begin
        case (s_araddr)
            kb_pkg::REG_DATA:   rd_word = data_word;
            kb_pkg::REG_STATUS: rd_word = status_word;
            default:            rd_word = 32'h0; // CTRL reads back zero
        endcase
    end

    // ------------------------------------------------------------------------
    // write channel, AW and W taken together
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            s_bvalid  <= 1'b0;
        end else begin
            s_awready <= !s_awready && s_awvalid && s_wvalid && !s_bvalid;
            s_wready  <= !s_awready && s_awvalid && s_wvalid && !s_bvalid;
            if (wr_hs) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            s_bresp <= wr_known ? kb_pkg::RESP_OKAY : kb_pkg::RESP_SLVERR;
        end
    end

    // ------------------------------------------------------------------------
    // read channel
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
        end else begin
            s_arready <= !s_arready && s_arvalid && !s_rvalid;
            if (rd_hs) begin
                s_rvalid <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            s_rdata <= rd_word;
            s_rresp <= rd_known ? kb_pkg::RESP_OKAY : kb_pkg::RESP_SLVERR;
        end
    end

    // sticky frame error
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ferr_q <= 1'b0;
        end else if (frame_err) begin
            ferr_q <= 1'b1;
        end else if (ctrl_clr) begin
            ferr_q <= 1'b0;
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));

    a_fifo_count: assert property (@(posedge clk) disable iff (!rst)
        count <= 8'(FIFO_DEPTH));

endmodule

// ==== src/kb_decoder.sv ====
module kb_decoder (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       cnt_clr,
    output logic       emit,
    output logic [7:0] emit_scan,
    output logic       emit_shift,
    output logic       emit_ctrl,
    output logic [7:0] release_cnt
);

    typedef enum logic {
        ST_MAKE,
        ST_BREAK
    } state_t;

    state_t state;
    logic   is_break;
    logic   is_ext;
    logic   is_shift;
    logic   is_ctrl;

    assign is_break = (rx_data == kb_pkg::SC_BREAK);
    assign is_ext   = (rx_data == kb_pkg::SC_EXT);
    assign is_shift = (rx_data == kb_pkg::SC_LSHIFT) || (rx_data == kb_pkg::SC_RSHIFT);
    assign is_ctrl  = (rx_data == kb_pkg::SC_CTRL);

    // ------------------------------------------------------------------------
    // make / break tracking with modifier state
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= ST_MAKE;
            emit       <= 1'b0;
            emit_shift <= 1'b0;
            emit_ctrl  <= 1'b0;
        end else begin
            emit <= 1'b0;
            if (rx_valid && !is_ext) begin
                if (is_break) begin
                    state <= ST_BREAK;
                end else if (state == ST_BREAK) begin
                    state <= ST_MAKE; // released key, nothing emitted
                    if (is_shift) begin
                        emit_shift <= 1'b0;
                    end
                    if (is_ctrl) begin
                        emit_ctrl <= 1'b0;
                    end
                end else if (is_shift) begin
                    emit_shift <= 1'b1;
                end else if (is_ctrl) begin
                    emit_ctrl <= 1'b1;
                end else begin
                    emit <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            emit_scan <= rx_data;
        end
    end

    // one count per F0, wraps
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            release_cnt <= '0;
        end else if (cnt_clr) begin
            release_cnt <= '0;
        end else if (rx_valid && is_break) begin
            release_cnt <= release_cnt + 8'd1;
        end
    end

    a_emit_after_rx: assert property (@(posedge clk) disable iff (!rst)
        emit |-> $past(rx_valid));

endmodule

// ==== src/kb_pkg.sv ====
package kb_pkg;

    // scan codes, set 2
    localparam logic [7:0] SC_BREAK  = 8'hF0;
    localparam logic [7:0] SC_EXT    = 8'hE0;
    localparam logic [7:0] SC_LSHIFT = 8'h12;
    localparam logic [7:0] SC_RSHIFT = 8'h59;
    localparam logic [7:0] SC_CTRL   = 8'h14;

    typedef struct packed {
        logic [7:0] scan;
        logic [7:0] ascii;
        logic       shift;
        logic       ctrl;
    } key_event_t;

    // ------------------------------------------------------------------------
    // register map, byte offsets
    // DATA   : [31] valid, [17] ctrl, [16] shift, [15:8] ascii, [7:0] scan
    // STATUS : [7:0] fifo count, [8] overflow, [9] frame error,
    //          [23:16] release count
    // CTRL   : [0] write 1 clears overflow, frame error and release count
    // ------------------------------------------------------------------------
    localparam logic [3:0] REG_DATA   = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_CTRL   = 4'h8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== src/key_fifo.sv ====
module key_fifo #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = kb_pkg::key_event_t
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  payload_t   wdata,
    input  logic       pop,
    input  logic       ovf_clr,
    output payload_t   rdata,
    output logic       empty,
    output logic [7:0] count,
    output logic       overflow
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic            full;
    logic            do_push;
    logic            do_pop;

    assign empty   = (count == 8'd0);
    assign full    = (count == 8'(DEPTH));
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop); // room freed by a same-cycle pop
    assign rdata   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 8'd1;
            end else if (do_pop && !do_push) begin
                count <= count - 8'd1;
            end
            if (push && !do_push) begin
                overflow <= 1'b1;
            end else if (ovf_clr) begin
                overflow <= 1'b0;
            end
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (!rst)
        count <= 8'(DEPTH));

endmodule

// ==== src/ps2_kbd_top.sv ====
module ps2_kbd_top #(
    parameter int FIFO_DEPTH   = 8,
    parameter int IDLE_TIMEOUT = 2000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ps2_clk,
    input  logic        ps2_data,
    input  logic [3:0]  s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic [3:0]  s_wstrb,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [3:0]  s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready
);

    logic [7:0]         rx_data;
    logic               rx_valid;
    logic               frame_err;
    logic               emit;
    logic [7:0]         emit_scan;
    logic               emit_shift;
    logic               emit_ctrl;
    logic [7:0]         release_cnt;
    logic               cnt_clr;
    logic               ev_valid;
    kb_pkg::key_event_t ev;
    kb_pkg::key_event_t fifo_rdata;
    logic               fifo_empty;
    logic [7:0]         fifo_count;
    logic               fifo_overflow;
    logic               fifo_pop;
    logic               ovf_clr;

    ps2_rx #(
        .IDLE_TIMEOUT(IDLE_TIMEOUT)
    ) u_rx (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .frame_err(frame_err)
    );

    kb_decoder u_dec (
        .clk        (clk),
        .rst        (rst),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .cnt_clr    (cnt_clr),
        .emit       (emit),
        .emit_scan  (emit_scan),
        .emit_shift (emit_shift),
        .emit_ctrl  (emit_ctrl),
        .release_cnt(release_cnt)
    );

    scan_to_ascii u_lut (
        .clk       (clk),
        .rst       (rst),
        .emit      (emit),
        .emit_scan (emit_scan),
        .emit_shift(emit_shift),
        .emit_ctrl (emit_ctrl),
        .ev_valid  (ev_valid),
        .ev        (ev)
    );

    key_fifo #(
        .DEPTH    (FIFO_DEPTH),
        .payload_t(kb_pkg::key_event_t)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (ev_valid),
        .wdata   (ev),
        .pop     (fifo_pop),
        .ovf_clr (ovf_clr),
        .rdata   (fifo_rdata),
        .empty   (fifo_empty),
        .count   (fifo_count),
        .overflow(fifo_overflow)
    );

    kb_axil_regs #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .s_awaddr   (s_awaddr),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .s_wdata    (s_wdata),
        .s_wstrb    (s_wstrb),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .s_bresp    (s_bresp),
        .s_bvalid   (s_bvalid),
        .s_bready   (s_bready),
        .s_araddr   (s_araddr),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .s_rdata    (s_rdata),
        .s_rresp    (s_rresp),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .rdata      (fifo_rdata),
        .empty      (fifo_empty),
        .count      (fifo_count),
        .overflow   (fifo_overflow),
        .frame_err  (frame_err),
        .release_cnt(release_cnt),
        .pop        (fifo_pop),
        .ovf_clr    (ovf_clr),
        .cnt_clr    (cnt_clr)
    );

endmodule

// ==== src/ps2_rx.sv ====
module ps2_rx #(
    parameter int IDLE_TIMEOUT = 2000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       frame_err
);

    localparam int IW = $clog2(IDLE_TIMEOUT + 1);

    logic [2:0]    clk_sync;
    logic [1:0]    data_sync;
    logic          clk_fall;
    logic          bit_in;
    logic          frame_ok;
    logic          idle_hit;
    logic [3:0]    bit_cnt;   // 0 idle, 1..9 data+parity, 10 stop
    logic [8:0]    shreg;
    logic [IW-1:0] idle_cnt;

    // lines idle high
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign clk_fall = clk_sync[2] & ~clk_sync[1];
    assign bit_in   = data_sync[1];
    assign frame_ok = bit_in & (^shreg); // stop high, odd parity
    assign idle_hit = (idle_cnt == IW'(IDLE_TIMEOUT - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bit_cnt   <= '0;
            idle_cnt  <= '0;
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd0) begin
                    if (!bit_in) begin
                        bit_cnt <= 4'd1; // start bit
                    end
                end else if (bit_cnt == 4'd10) begin
                    bit_cnt   <= '0;
                    rx_valid  <= frame_ok;
                    frame_err <= ~frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                if (idle_hit) begin
                    bit_cnt  <= '0; // stalled frame, drop it
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // lsb first, parity ends up in bit 8
    always_ff @(posedge clk) begin
        if (clk_fall && bit_cnt != 4'd0 && bit_cnt != 4'd10) begin
            shreg <= {bit_in, shreg[8:1]};
        end
        if (clk_fall && bit_cnt == 4'd10) begin
            rx_data <= shreg[7:0];
        end
    end

    a_rx_excl: assert property (@(posedge clk) disable iff (!rst)
        !(rx_valid && frame_err));

endmodule

// ==== src/scan_to_ascii.sv ====
module scan_to_ascii (
    input  logic               clk,
    input  logic               rst,
    input  logic               emit,
    input  logic [7:0]         emit_scan,
    input  logic               emit_shift,
    input  logic               emit_ctrl,
    output logic               ev_valid,
    output kb_pkg::key_event_t ev
);

    logic [7:0] base;
    logic [7:0] ascii;

    always_comb begin
        case (emit_scan)
            8'h45: base = 8'h30; // 0
            8'h16: base = 8'h31;
            8'h1E: base = 8'h32;
            8'h26: base = 8'h33;
            8'h25: base = 8'h34;
            8'h2E: base = 8'h35;
            8'h36: base = 8'h36;
            8'h3D: base = 8'h37;
            8'h3E: base = 8'h38;
            8'h46: base = 8'h39;
            8'h1C: base = 8'h61; // a
            8'h32: base = 8'h62;
            8'h21: base = 8'h63;
            8'h23: base = 8'h64;
            8'h24: base = 8'h65;
            8'h2B: base = 8'h66;
            8'h34: base = 8'h67;
            8'h33: base = 8'h68;
            8'h43: base = 8'h69;
            8'h3B: base = 8'h6A;
            8'h42: base = 8'h6B;
            8'h4B: base = 8'h6C;
            8'h3A: base = 8'h6D;
            8'h31: base = 8'h6E;
            8'h44: base = 8'h6F;
            8'h4D: base = 8'h70;
            8'h15: base = 8'h71;
            8'h2D: base = 8'h72;
            8'h1B: base = 8'h73;
            8'h2C: base = 8'h74;
            8'h3C: base = 8'h75;
            8'h2A: base = 8'h76;
            8'h1D: base = 8'h77;
            8'h22: base = 8'h78;
            8'h35: base = 8'h79;
            8'h1A: base = 8'h7A; // z
            default: base = 8'h00;
        endcase
    end

    // shift only touches letters
    assign ascii = (emit_shift && base >= 8'h61) ? base - 8'h20 : base;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ev_valid <= 1'b0;
        end else begin
            ev_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            ev.scan  <= emit_scan;
            ev.ascii <= ascii;
            ev.shift <= emit_shift;
            ev.ctrl  <= emit_ctrl;
        end
    end

endmodule

// ==== tb/tb_ps2_kbd_tasks.svh ====
// set 2 make codes, digits 0-9 then letters a-z
localparam logic [8*36-1:0] KEY_CODES = {
    8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46,
    8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
    8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
    8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
};

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic logic [7:0] key_code(input int idx);
    return KEY_CODES[8*(35-idx) +: 8];
endfunction

function automatic logic [7:0] pick_key();
    return key_code(int'((lcg_next() >> 16) % 36)); // upper bits, low ones cycle fast
endfunction

// expected DATA word for one key event
function automatic logic [31:0] ref_event(input logic [7:0] scan, input logic shift,
                                          input logic ctrl);
    logic [7:0] ascii;
    int i;
    ascii = 8'h00;
    for (i = 0; i < 36; i++) begin
        if (key_code(i) == scan) begin
            if (i < 10) begin
                ascii = 8'(8'h30 + i);
            end else begin
                ascii = 8'((shift ? 8'h41 : 8'h61) + (i - 10));
            end
        end
    end
    return {1'b1, 13'h0, ctrl, shift, ascii, scan};
endfunction

function automatic kb_pkg::key_event_t word_event(input logic [31:0] w);
    kb_pkg::key_event_t e;
    e.scan  = w[7:0];
    e.ascii = w[15:8];
    e.shift = w[16];
    e.ctrl  = w[17];
    return e;
endfunction

function automatic logic [31:0] exp_status(input logic [7:0] cnt, input logic ovf,
                                           input logic ferr, input logic [7:0] rel);
    return {8'h0, rel, 6'h0, ferr, ovf, cnt};
endfunction

// ----------------------------------------------------------------------------
// keyboard side
// ----------------------------------------------------------------------------
task automatic send_frame(input logic [7:0] b, input logic bad_parity);
    logic [10:0] bits;
    int i;
    bits = {1'b1, ~(^b) ^ bad_parity, b, 1'b0};
    @(negedge clk);
    for (i = 0; i < 11; i++) begin
        ps2_data = bits[i]; // changes while ps2_clk is high
        repeat (HALF_BIT) @(negedge clk);
        ps2_clk = 1'b0;
        repeat (HALF_BIT) @(negedge clk);
        ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    repeat (FRAME_GAP) @(negedge clk);
    if (!bad_parity && b == kb_pkg::SC_BREAK) begin
        rel_exp = rel_exp + 8'd1;
    end
endtask

task automatic press_key(input logic [7:0] sc);
    send_frame(sc, 1'b0);
endtask

task automatic release_key(input logic [7:0] sc);
    send_frame(kb_pkg::SC_BREAK, 1'b0);
    send_frame(sc, 1'b0);
endtask

task automatic tap_key(input logic [7:0] sc);
    press_key(sc);
    release_key(sc);
endtask

// ----------------------------------------------------------------------------
// host side
// ----------------------------------------------------------------------------
task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    @(negedge clk);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    s_rready  = 1'b1;
    @(negedge clk);
    while (!s_arready) @(negedge clk);
    @(negedge clk); // handshake done on the edge before
    s_arvalid = 1'b0;
    while (!s_rvalid) @(negedge clk);
    data = s_rdata;
    resp = s_rresp;
    @(negedge clk);
    s_rready = 1'b0;
endtask

task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                         output logic [1:0] resp);
    @(negedge clk);
    s_awaddr  = addr;
    s_wdata   = data;
    s_wstrb   = 4'hF;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    s_bready  = 1'b1;
    @(negedge clk);
    while (!(s_awready && s_wready)) @(negedge clk);
    @(negedge clk);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    while (!s_bvalid) @(negedge clk);
    resp = s_bresp;
    @(negedge clk);
    s_bready = 1'b0;
endtask

task automatic clear_ctrl();
    logic [1:0] resp;
    axi_write(kb_pkg::REG_CTRL, 32'h1, resp);
    check_resp("ctrl write", kb_pkg::RESP_OKAY, resp);
    rel_exp = 8'd0;
endtask

// poll STATUS until something is queued, then pop it
task automatic fetch_event(output logic [31:0] word);
    logic [31:0] st;
    logic [1:0]  resp;
    st = 32'h0;
    while (st[7:0] == 8'd0) begin
        axi_read(kb_pkg::REG_STATUS, st, resp);
    end
    axi_read(kb_pkg::REG_DATA, word, resp);
endtask

// ----------------------------------------------------------------------------
// compare
// ----------------------------------------------------------------------------
task automatic check_event(input string label, input logic [31:0] exp_word,
                           input logic [31:0] act_word);
    kb_pkg::key_event_t exp_ev;
    kb_pkg::key_event_t act_ev;
    exp_ev = word_event(exp_word);
    act_ev = word_event(act_word);
    checks++;
    if (act_word[31] !== exp_word[31] || act_ev !== exp_ev || act_word[30:18] !== 13'h0) begin
        test_errs++;
        $display("Fail %s/%s: expected valid=%0b ev=%h, actual valid=%0b ev=%h (word %h)",
                 cur_test, label, exp_word[31], exp_ev, act_word[31], act_ev, act_word);
    end
endtask

task automatic check_status(input string label, input logic [31:0] exp,
                            input logic [31:0] act);
    checks++;
    if (act !== exp) begin
        test_errs++;
        $display("Fail %s/%s: expected %h, actual %h", cur_test, label, exp, act);
    end
endtask

task automatic check_resp(input string label, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp) begin
        test_errs++;
        $display("Fail %s/%s: expected resp %b, actual resp %b", cur_test, label, exp, act);
    end
endtask

task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
endtask

task automatic end_test();
    n_tests++;
    total_errs += test_errs;
    if (test_errs == 0) begin
        $display("test %s: ok", cur_test);
    end else begin
        failed_tests++;
        $display("test %s: %0d errors", cur_test, test_errs);
    end
endtask

// ==== tb/tb_ps2_kbd.sv ====
module tb_ps2_kbd;

    localparam int FIFO_DEPTH   = 4;
    localparam int IDLE_TIMEOUT = 200;
    localparam int HALF_BIT     = 20;  // ps2_clk half period in clocks
    localparam int FRAME_GAP    = 40;
    localparam int N_FRAMES     = 100; // every frame sent by the tests below
    localparam int WD_CLOCKS    = N_FRAMES * 11 * 2 * HALF_BIT + 20000;

    logic        clk;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_data;
    logic [3:0]  s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic [3:0]  s_wstrb;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [3:0]  s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;

    logic [31:0] lcg_state;
    logic [7:0]  rel_exp;      // F0 bytes sent since the last clear
    string       cur_test;
    int          test_errs;
    int          total_errs;
    int          checks;
    int          n_tests;
    int          failed_tests;
    logic [31:0] exp_q [$];

    `include "tb_ps2_kbd_tasks.svh"

    ps2_kbd_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .IDLE_TIMEOUT(IDLE_TIMEOUT)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .s_awaddr (s_awaddr),
        .s_awvalid(s_awvalid),
        .s_awready(s_awready),
        .s_wdata  (s_wdata),
        .s_wstrb  (s_wstrb),
        .s_wvalid (s_wvalid),
        .s_wready (s_wready),
        .s_bresp  (s_bresp),
        .s_bvalid (s_bvalid),
        .s_bready (s_bready),
        .s_araddr (s_araddr),
        .s_arvalid(s_arvalid),
        .s_arready(s_arready),
        .s_rdata  (s_rdata),
        .s_rresp  (s_rresp),
        .s_rvalid (s_rvalid),
        .s_rready (s_rready)
    );

    always #5 clk = ~clk;

    initial begin : watchdog
        repeat (WD_CLOCKS) @(posedge clk);
        $display("watchdog: run did not finish within %0d clocks, stopped", WD_CLOCKS);
        $display("Regression failed");
        $finish;
    end

    initial begin : main_seq
        int          k;
        logic [7:0]  sc;
        logic [31:0] word;
        logic [31:0] st;
        logic [1:0]  resp;
        logic [31:0] held [$];

        clk       = 1'b0;
        rst       = 1'b0;
        ps2_clk   = 1'b1; // open drain, idle high
        ps2_data  = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        lcg_state = 32'd66958;
        rel_exp   = 8'd0;
        test_errs = 0;
        total_errs   = 0;
        checks       = 0;
        n_tests      = 0;
        failed_tests = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        repeat (4) @(negedge clk);

        begin_test("reset");
        axi_read(kb_pkg::REG_STATUS, st, resp);
        check_resp("status resp", kb_pkg::RESP_OKAY, resp);
        check_status("status", 32'h0, st);
        axi_read(kb_pkg::REG_DATA, word, resp);
        check_event("empty data", 32'h0, word);
        end_test();

        // ------------------------------------------------------------------------
        // keyboard and host run side by side
        // ------------------------------------------------------------------------
        begin_test("random keys");
        fork
            begin : sender
                int         j;
                logic [7:0] key;
                for (j = 0; j < 20; j++) begin
                    key = pick_key();
                    exp_q.push_back(ref_event(key, 1'b0, 1'b0));
                    tap_key(key);
                end
            end
            begin : reader
                int          j;
                logic [31:0] got;
                for (j = 0; j < 20; j++) begin
                    fetch_event(got);
                    check_event($sformatf("key %0d", j), exp_q.pop_front(), got);
                end
            end
        join
        axi_read(kb_pkg::REG_STATUS, st, resp);
        check_status("release count", exp_status(8'd0, 1'b0, 1'b0, 8'd20), st);
        end_test();

        begin_test("modifiers");
        press_key(kb_pkg::SC_LSHIFT);
        tap_key(8'h15);
        release_key(kb_pkg::SC_LSHIFT);
        press_key(kb_pkg::SC_RSHIFT);
        tap_key(8'h3D);
        release_key(kb_pkg::SC_RSHIFT);
        press_key(kb_pkg::SC_CTRL);
        tap_key(8'h1C);
        release_key(kb_pkg::SC_CTRL);
        tap_key(8'h2C);                  // both modifiers up again
        fetch_event(word);
        check_event("shift letter", ref_event(8'h15, 1'b1, 1'b0), word);
        fetch_event(word);
        check_event("shift digit", ref_event(8'h3D, 1'b1, 1'b0), word);
        fetch_event(word);
        check_event("ctrl key", ref_event(8'h1C, 1'b0, 1'b1), word);
        fetch_event(word);
        check_event("plain key", ref_event(8'h2C, 1'b0, 1'b0), word);
        axi_read(kb_pkg::REG_STATUS, st, resp);
        check_status("status", exp_status(8'd0, 1'b0, 1'b0, rel_exp), st);
        end_test();

        begin_test("overflow");
        for (k = 0; k < 6; k++) begin
            sc = pick_key();
            held.push_back(ref_event(sc, 1'b0, 1'b0));
            tap_key(sc);
        end
        axi_read(kb_pkg::REG_STATUS, st, resp);
        check_status("full", exp_status(8'(FIFO_DEPTH), 1'b1, 1'b0, rel_exp), st);
        for (k = 0; k < FIFO_DEPTH; k++) begin
            axi_read(kb_pkg::REG_DATA, word, resp);
            check_event($sformatf("entry %0d", k), held[k], word);
        end
        axi_read(kb_pkg::REG_DATA, word, resp);
        check_event("drained", 32'h0, word);
        clear_ctrl();
        axi_read(kb_pkg::REG_STATUS, st, resp);
        check_status("cleared", exp_status(8'd0, 1'b0, 1'b0, rel_exp), st);
        end_test();

        begin_test("frame error");
        send_frame(8'h1C, 1'b1);
        axi_read(kb_pkg::REG_STATUS, st, resp);
        check_status("bad parity", exp_status(8'd0, 1'b0, 1'b1, rel_exp), st);
        clear_ctrl();
        axi_read(kb_pkg::REG_STATUS, st, resp);
        check_status("cleared", exp_status(8'd0, 1'b0, 1'b0, rel_exp), st);
        end_test();

        begin_test("address map");
        axi_read(4'hC, word, resp);
        check_resp("read 0xC", kb_pkg::RESP_SLVERR, resp);
        check_status("read 0xC data", 32'h0, word);
        axi_write(kb_pkg::REG_STATUS, 32'hFFFF_FFFF, resp);
        check_resp("write status", kb_pkg::RESP_OKAY, resp);
        axi_read(kb_pkg::REG_STATUS, st, resp);
        check_status("status kept", exp_status(8'd0, 1'b0, 1'b0, rel_exp), st);
        end_test();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, failed_tests, checks, total_errs);
        if (total_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
